// ==== common/mem_pkg.sv ====
// memory command unit package with operation codes, width types and the records between stages
package mem_pkg;

	// default geometry of the RAM, overridden through the top level parameters.
	localparam int ADDR_BITS = 8;
	localparam int WORD_BITS = 8;
	localparam int NUM_PORTS = 2;

	// a RAM address.
	typedef logic [ADDR_BITS-1:0] addr_t;

	// one data word as stored in the RAM and returned to the host.
	typedef logic [WORD_BITS-1:0] word_t;

	// host operations, two bits wide on the command bus.
	typedef enum logic [1:0] {
		op_read  = 2'd0,	// return the stored word.
		op_write = 2'd1,	// store data and return it.
		op_add   = 2'd2,	// add the operand, store and return the sum.
		op_swap  = 2'd3		// store data and return the previous word.
	} mem_op_e;

	// host command as presented with req.
	typedef struct packed {
		mem_op_e op;		// operation to run.
		addr_t   addr;		// target word.
		word_t   data;		// write data, or the operand for op_add.
	} mem_cmd_t;

	// decoded request from the decoder to the execute stage.
	typedef struct packed {
		mem_op_e op;
		addr_t   addr;
		word_t   data;
		logic    needs_write;	// set when the operation stores a new word.
	} mem_req_t;

	// response from the execute stage to the result stage.
	typedef struct packed {
		word_t word;		// word handed back to the host.
	} mem_rsp_t;

	// the old word is returned for read and swap, the new word otherwise.
	function automatic logic returns_old(input mem_op_e op);
		return (op == op_read) || (op == op_swap);
	endfunction

	// every operation except a plain read writes the RAM.
	function automatic logic op_writes(input mem_op_e op);
		return op != op_read;
	endfunction

	// new word to store for a given operation and old word.
	function automatic word_t new_word(input mem_op_e op, input word_t old_word,
			input word_t data);
		word_t sum;
		sum = old_word + data;		// wraps modulo the word size.
		if (op == op_add) begin
			return sum;
		end
		return data;
	endfunction

endpackage

// ==== ram/ram.sv ====
// multi-port synchronous RAM with separate read and write enables per port
module ram
	import mem_pkg::*;
#(
	parameter int NUM_PORTS = mem_pkg::NUM_PORTS,
	parameter int ADDR_BITS = mem_pkg::ADDR_BITS,
	parameter int WORD_BITS = mem_pkg::WORD_BITS
) (
	input  logic                  clk,
	input  logic                  rst_n,

	// port controls, one bit per port.
	input  logic [NUM_PORTS-1:0]  read_ena,
	input  logic [NUM_PORTS-1:0]  write_ena,

	// per port address, write data and read data.
	input  addr_t [NUM_PORTS-1:0] addr,
	input  word_t [NUM_PORTS-1:0] data,
	output word_t [NUM_PORTS-1:0] out_data
);

	localparam int DEPTH = 2 ** ADDR_BITS;

	// storage array, one entry per address.
	logic [WORD_BITS-1:0] words [DEPTH];

	// writes land on the clock edge, so a read from another port in the same
	// cycle still sees the previous contents.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				words[i] <= '0;		// the whole array comes up as zero.
			end
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (write_ena[p]) begin
					words[addr[p]] <= data[p];	// higher ports win on a collision.
				end
			end
		end
	end

	// synchronous read, the output holds its value while read_ena is low.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_data <= '0;
		end else begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				if (read_ena[p]) begin
					out_data[p] <= words[addr[p]];
				end
			end
		end
	end

endmodule

// ==== verilog/cmd_decode.sv ====
// req/ack command slave that captures a host command and issues one decoded request
module cmd_decode
	import mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	// host side.
	input  logic     req,
	input  mem_cmd_t cmd,

	// re-arm from the result stage once the handshake has closed.
	input  logic     done,

	// toward the execute stage.
	output logic     req_valid,
	output mem_req_t dec
);

	typedef enum logic [1:0] {
		dec_idle,	// waiting for req.
		dec_split,	// command captured, building the request.
		dec_wait	// request issued, waiting for done.
	} dec_state_e;

	dec_state_e state;
	mem_cmd_t   cmd_q;		// command as sampled with req.

	// control path.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= dec_idle;
			req_valid <= 1'b0;
		end else begin
			req_valid <= 1'b0;
			case (state)
				dec_idle: begin
					if (req) begin
						state <= dec_split;
					end
				end
				dec_split: begin
					req_valid <= 1'b1;		// single cycle strobe.
					state     <= dec_wait;
				end
				dec_wait: begin
					// a held req is ignored here, only done frees the decoder.
					if (done) begin
						state <= dec_idle;
					end
				end
				default: state <= dec_idle;
			endcase
		end
	end

	// payload path.
	always_ff @(posedge clk) begin
		if (state == dec_idle && req) begin
			cmd_q <= cmd;
		end
		if (state == dec_split) begin
			dec.op          <= cmd_q.op;
			dec.addr        <= cmd_q.addr;
			dec.data        <= cmd_q.data;
			dec.needs_write <= op_writes(cmd_q.op);	// write, add and swap.
		end
	end

endmodule

// ==== verilog/mem_execute.sv ====
// execute stage that reads the old word, computes the new one and writes it back
module mem_execute
	import mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	// decoded request.
	input  logic     req_valid,
	input  mem_req_t dec,

	// RAM access, reads on port 0 and writes on port 1.
	output logic     read_ena,
	output logic     write_ena,
	output addr_t    addr,
	output word_t    wdata,
	input  word_t    rdata,

	// toward the result stage.
	output logic     rsp_valid,
	output mem_rsp_t rsp
);

	typedef enum logic [1:0] {
		st_idle,	// waiting for req_valid.
		st_read,	// read issued on port 0.
		st_compute,	// read data valid, write through port 1.
		st_respond	// response presented for one cycle.
	} ex_state_e;

	ex_state_e state;
	mem_req_t  req_q;		// request under execution.
	word_t     next_word;		// word to be stored.

	// every operation walks the same path, so the latency never changes.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (req_valid) begin
						state <= st_read;
					end
				end
				st_read:    state <= st_compute;
				st_compute: state <= st_respond;
				st_respond: state <= st_idle;
				default:    state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && req_valid) begin
			req_q <= dec;
		end
		if (state == st_compute) begin
			// read and swap hand back the old word, write and add the new one.
			if (returns_old(req_q.op)) begin
				rsp.word <= rdata;
			end else begin
				rsp.word <= next_word;
			end
		end
	end

	// sum or plain data, depending on the operation.
	assign next_word = new_word(req_q.op, rdata, req_q.data);

	// RAM controls follow the state directly.
	assign read_ena  = (state == st_read);
	assign write_ena = (state == st_compute) && req_q.needs_write;
	assign addr      = req_q.addr;
	assign wdata     = next_word;

	assign rsp_valid = (state == st_respond);

endmodule

// ==== verilog/result_return.sv ====
// result stage that holds the returned word and closes the four-phase handshake
module result_return
	import mem_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,

	// response from the execute stage.
	input  logic     rsp_valid,
	input  mem_rsp_t rsp,

	// host side.
	input  logic     req,
	output logic     ack,
	output word_t    result,

	// pulses once the host has seen ack and released req.
	output logic     done
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack    <= 1'b0;
			result <= '0;
			done   <= 1'b0;
		end else begin
			done <= 1'b0;
			if (rsp_valid) begin
				result <= rsp.word;		// stays valid until the next response.
				ack    <= 1'b1;
			end else if (ack && !req) begin
				// host has dropped req, finish the handshake.
				ack  <= 1'b0;
				done <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/mem_unit.sv ====
// memory command unit top level joining decode, execute, result and the RAM
module mem_unit
	import mem_pkg::*;
#(
	parameter int NUM_PORTS = mem_pkg::NUM_PORTS,
	parameter int ADDR_BITS = mem_pkg::ADDR_BITS,
	parameter int WORD_BITS = mem_pkg::WORD_BITS
) (
	input  logic     clk,
	input  logic     rst_n,

	// host handshake.
	input  logic     req,
	input  mem_cmd_t cmd,
	output logic     ack,
	output word_t    result
);

	logic     req_valid;
	mem_req_t dec;
	logic     rsp_valid;
	mem_rsp_t rsp;
	logic     done;

	// execute stage view of the RAM.
	logic     ex_read_ena;
	logic     ex_write_ena;
	addr_t    ex_addr;
	word_t    ex_wdata;

	// full RAM port bundle.
	logic  [NUM_PORTS-1:0] ram_read_ena;
	logic  [NUM_PORTS-1:0] ram_write_ena;
	addr_t [NUM_PORTS-1:0] ram_addr;
	word_t [NUM_PORTS-1:0] ram_data;
	word_t [NUM_PORTS-1:0] ram_out_data;

	// port 0 reads and port 1 writes, both at the same address.
	assign ram_read_ena  = NUM_PORTS'(ex_read_ena);
	assign ram_write_ena = NUM_PORTS'(ex_write_ena) << 1;
	assign ram_addr      = {NUM_PORTS{ex_addr}};
	assign ram_data      = {NUM_PORTS{ex_wdata}};

	cmd_decode u_decode (
		.clk(clk), .rst_n(rst_n),
		.req(req), .cmd(cmd), .done(done),
		.req_valid(req_valid), .dec(dec)
	);

	mem_execute u_execute (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .dec(dec),
		.read_ena(ex_read_ena), .write_ena(ex_write_ena),
		.addr(ex_addr), .wdata(ex_wdata), .rdata(ram_out_data[0]),
		.rsp_valid(rsp_valid), .rsp(rsp)
	);

	result_return u_result (
		.clk(clk), .rst_n(rst_n),
		.rsp_valid(rsp_valid), .rsp(rsp), .req(req),
		.ack(ack), .result(result), .done(done)
	);

	ram #(.NUM_PORTS(NUM_PORTS), .ADDR_BITS(ADDR_BITS), .WORD_BITS(WORD_BITS)) u_ram (
		.clk(clk), .rst_n(rst_n),
		.read_ena(ram_read_ena), .write_ena(ram_write_ena),
		.addr(ram_addr), .data(ram_data), .out_data(ram_out_data)
	);

endmodule

// ==== tests/mem_unit_tb.sv ====
// testbench for the memory command unit, driving four-phase commands against a shadow model
module mem_unit_tb
	import mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 10;
	localparam int HOLD_CYCLES  = 20;
	localparam int RANDOM_CMDS  = 200;
	localparam int NUM_CMDS     = 14 + RANDOM_CMDS;	// directed tests plus the random run.
	localparam int WATCHDOG_NS  = NUM_CMDS * 12 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
	localparam int ACK_LATENCY  = 5;

	logic     clk;
	logic     rst_n;
	logic     req;
	mem_cmd_t cmd;
	logic     ack;
	word_t    result;

	word_t    shadow [256];	// expected RAM contents.
	word_t    exp_q [$];	// expected results in command order.
	word_t    expected;
	logic     ack_seen;
	logic [31:0] rnd;
	integer   seed;
	int       checks;
	int       errors;
	int       commands;
	int       test_start;

	mem_unit #(.NUM_PORTS(2), .ADDR_BITS(8), .WORD_BITS(8)) dut (
		.clk(clk), .rst_n(rst_n),
		.req(req), .cmd(cmd),
		.ack(ack), .result(result)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// expected result of one command, updating the shadow memory on the way.
	function automatic word_t predict(input mem_cmd_t c);
		word_t old_word;
		word_t stored;
		old_word = shadow[c.addr];
		case (c.op)
			op_read:  stored = old_word;
			op_write: stored = c.data;
			op_add:   stored = old_word + c.data;	// eight bit sum drops the carry.
			default:  stored = c.data;
		endcase
		shadow[c.addr] = stored;
		if (c.op == op_read || c.op == op_swap) begin
			return old_word;
		end
		return stored;
	endfunction

	// result is checked once on every rising ack.
	always @(negedge clk) begin
		if (!rst_n) begin
			ack_seen = 1'b0;
		end else begin
			if (ack && !ack_seen) begin
				assert (exp_q.size() > 0) else begin
					$display("ack rose with no command outstanding");
					errors++;
				end
				if (exp_q.size() > 0) begin
					expected = exp_q.pop_front();
					checks++;
					assert (result === expected) else begin
						$display("Fail result expected %h got %h", expected, result);
						errors++;
					end
				end
			end
			ack_seen = ack;
		end
	end

	// one full four-phase handshake, optionally holding req after ack.
	task automatic send(input mem_op_e op, input addr_t a, input word_t d, input int hold);
		mem_cmd_t c;
		int       n;
		int       lat;
		c.op   = op;
		c.addr = a;
		c.data = d;
		exp_q.push_back(predict(c));
		commands++;
		@(posedge clk);
		cmd <= c;
		req <= 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!ack);
		lat = n - 2;		// req is driven on one edge and sampled on the next.
		checks++;
		assert (lat == ACK_LATENCY) else begin
			$display("ack rose %0d cycles after req was sampled instead of %0d", lat,
				ACK_LATENCY);
			errors++;
		end
		for (int i = 0; i < hold; i++) begin
			@(negedge clk);
			checks++;
			assert (ack === 1'b1) else begin
				$display("ack fell while req was still held, %0d cycles into the hold", i);
				errors++;
			end
		end
		@(posedge clk);
		req <= 1'b0;
		do begin
			@(negedge clk);
		end while (ack);
	endtask

	task automatic report_test(input int num, input string name);
		if (errors == test_start) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, errors - test_start);
		end
		test_start = errors;
	endtask

	// ends the run if the DUT stops answering.
	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the commands did not finish within %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

	initial begin
		clk        = 1'b0;
		rst_n      = 1'b0;
		req        = 1'b0;
		cmd        = '0;
		seed       = 32'hfa86;
		checks     = 0;
		errors     = 0;
		commands   = 0;
		test_start = 0;
		for (int i = 0; i < 256; i++) begin
			shadow[i] = '0;	// RAM clears to zero on reset.
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		checks += 2;
		assert (ack === 1'b0) else begin
			$display("Fail ack expected 0 got %h", ack);
			errors++;
		end
		assert (result === 8'h00) else begin
			$display("Fail result expected 00 got %h", result);
			errors++;
		end
		send(op_read, 8'h00, 8'h00, 0);
		send(op_read, 8'h5a, 8'h00, 0);
		send(op_read, 8'hff, 8'h00, 0);
		report_test(1, "reset state");

		send(op_write, 8'h12, 8'hab, 0);
		send(op_read, 8'h12, 8'h00, 0);
		send(op_read, 8'hff, 8'h00, 0);
		report_test(2, "write and read");

		send(op_write, 8'h40, 8'h0f, 0);
		send(op_add, 8'h40, 8'hf5, 0);	// wraps to 04.
		send(op_read, 8'h40, 8'h00, 0);
		report_test(3, "add with wrap");

		send(op_write, 8'h77, 8'h3c, 0);
		send(op_swap, 8'h77, 8'hc3, 0);
		send(op_read, 8'h77, 8'h00, 0);
		report_test(4, "swap");

		// a second execution of the held add would leave 02 behind.
		send(op_add, 8'h90, 8'h01, HOLD_CYCLES);
		send(op_read, 8'h90, 8'h00, 0);
		report_test(5, "handshake hold");

		for (int i = 0; i < RANDOM_CMDS; i++) begin
			rnd = $random(seed);
			send(mem_op_e'(rnd[1:0]), rnd[15:8], rnd[23:16], 0);
		end
		report_test(6, "random commands");

		$display("commands %0d, checks %0d, errors %0d", commands, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
common/mem_pkg.sv
ram/ram.sv
verilog/cmd_decode.sv
verilog/mem_execute.sv
verilog/result_return.sv
verilog/mem_unit.sv
tests/mem_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module mem_unit_tb -f files.f -o mem_unit_sim \
	&& ./obj_dir/mem_unit_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1
